//--- vlog.f
+incdir+src
src/matmul_data_pkg.sv
src/matmul_cfg_pkg.sv
src/matmul_run_ctrl.sv
src/operand_ram.sv
src/systolic_data_setup.sv
src/systolic_mac_array.sv
src/matmul_top.sv
testbench/tb_matmul_top.sv

//--- testbench/tb_matmul_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "matmul_params.svh"

module tb_matmul_top
    import matmul_data_pkg::*;
    import matmul_cfg_pkg::*;
();

    localparam int SIZE         = `MAT_MUL_SIZE;
    localparam int NUM_CASES    = 10;
    localparam int DONE_TIMEOUT = 200;

    logic               clk;
    logic               arst_n;
    logic               start_mat_mul;
    run_cfg_t           cfg;
    logic               a_wr_en;
    logic [`AWIDTH-1:0] a_wr_addr;
    operand_row_u       a_wr_data;
    logic               b_wr_en;
    logic [`AWIDTH-1:0] b_wr_addr;
    operand_row_u       b_wr_data;
    result_matrix_t     result;
    logic               done;

    run_cfg_t    cfg_table [NUM_CASES];
    int          done_cycle_table [NUM_CASES];
    elem_t       mat_a [SIZE][SIZE];
    elem_t       mat_b [SIZE][SIZE];
    int unsigned expected [SIZE][SIZE];
    int          errors;

    matmul_top UUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .start_mat_mul (start_mat_mul),
        .cfg           (cfg),
        .a_wr_en       (a_wr_en),
        .a_wr_addr     (a_wr_addr),
        .a_wr_data     (a_wr_data),
        .b_wr_en       (b_wr_en),
        .b_wr_addr     (b_wr_addr),
        .b_wr_data     (b_wr_data),
        .result        (result),
        .done          (done)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Case table
    ////////////////////////////////////////////////////////////

    function automatic void add_case(
        input int                            idx,
        input logic [`AWIDTH-1:0]            base_a,
        input logic [`AWIDTH-1:0]            base_b,
        input logic [`ADDR_STRIDE_WIDTH-1:0] stride_a,
        input logic [`ADDR_STRIDE_WIDTH-1:0] stride_b,
        input logic [`MASK_WIDTH-1:0]        row_mask,
        input logic [`MASK_WIDTH-1:0]        k_mask,
        input logic [`MASK_WIDTH-1:0]        col_mask,
        input logic [`CNT_WIDTH-1:0]         size,
        input logic [`CNT_WIDTH-1:0]         slot,
        input int                            done_cycle
    );
        cfg_table[idx] = '{address_mat_a: base_a, address_mat_b: base_b,
                           address_stride_a: stride_a, address_stride_b: stride_b,
                           validity_mask_a_rows: row_mask,
                           validity_mask_a_cols_b_rows: k_mask,
                           validity_mask_b_cols: col_mask,
                           final_mat_mul_size: size, start_slot: slot};
        done_cycle_table[idx] = done_cycle;
    endfunction

    // The last column is the clk_cnt value slot*4 + N + 12 at which done must rise
    function automatic void load_case_table();
        //       base_a base_b str_a str_b  rows  k     cols  N     slot  done
        add_case(0, 6'd0,  6'd0,  6'd1, 6'd1,  4'hf, 4'hf, 4'hf, 8'd4, 8'd0, 16);
        add_case(1, 6'd8,  6'd20, 6'd3, 6'd5,  4'hf, 4'hf, 4'hf, 8'd4, 8'd0, 16);
        add_case(2, 6'd2,  6'd40, 6'd2, 6'd1,  4'h5, 4'hf, 4'hf, 8'd4, 8'd0, 16);
        add_case(3, 6'd1,  6'd1,  6'd1, 6'd1,  4'hf, 4'ha, 4'hf, 8'd4, 8'd0, 16);
        add_case(4, 6'd0,  6'd0,  6'd1, 6'd1,  4'hf, 4'hf, 4'h9, 8'd4, 8'd0, 16);
        add_case(5, 6'd12, 6'd5,  6'd4, 6'd7,  4'h6, 4'hd, 4'hb, 8'd4, 8'd1, 20);
        add_case(6, 6'd30, 6'd3,  6'd1, 6'd2,  4'hf, 4'hf, 4'hf, 8'd1, 8'd0, 13);
        add_case(7, 6'd4,  6'd50, 6'd5, 6'd3,  4'hf, 4'hf, 4'hf, 8'd2, 8'd2, 22);
        add_case(8, 6'd60, 6'd0,  6'd1, 6'd16, 4'h7, 4'he, 4'hf, 8'd3, 8'd1, 19);
        add_case(9, 6'd0,  6'd0,  6'd1, 6'd1,  4'hf, 4'hf, 4'hf, 8'd3, 8'd2, 23);
    endfunction

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    // Inputs change 1 ns after the rising edge
    task automatic wait_for_drive_slot();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input int unsigned got,
                               input int unsigned exp);
        assert (got == exp)
        else
        begin
            $display("MISMATCH time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
            errors++;
        end
    endtask

    // Column k of A and row k of B go out in the same write cycle
    task automatic fill_operands(input run_cfg_t c);
        for (int k = 0; k < SIZE; k++)
        begin
            wait_for_drive_slot();
            a_wr_en   = 1'b1;
            b_wr_en   = 1'b1;
            a_wr_addr = `AWIDTH'(c.address_mat_a + k * c.address_stride_a);
            b_wr_addr = `AWIDTH'(c.address_mat_b + k * c.address_stride_b);
            for (int n = 0; n < SIZE; n++)
            begin
                mat_a[n][k]       = elem_t'($urandom);
                mat_b[k][n]       = elem_t'($urandom);
                a_wr_data.lane[n] = mat_a[n][k];
                b_wr_data.lane[n] = mat_b[k][n];
            end
        end
        wait_for_drive_slot();
        a_wr_en = 1'b0;
        b_wr_en = 1'b0;
    endtask

    function automatic void compute_expected(input run_cfg_t c);
        int unsigned sum;
        for (int i = 0; i < SIZE; i++)
        begin
            for (int j = 0; j < SIZE; j++)
            begin
                sum = 0;
                for (int k = 0; k < int'(c.final_mat_mul_size); k++)
                begin
                    if (c.validity_mask_a_cols_b_rows[k])
                    begin
                        sum += int'(mat_a[i][k]) * int'(mat_b[k][j]);
                    end
                end
                // Masked rows of A and columns of B give zero entries
                if (!c.validity_mask_a_rows[i] || !c.validity_mask_b_cols[j])
                begin
                    sum = 0;
                end
                expected[i][j] = sum;
            end
        end
    endfunction

    // Sampled on the falling edge after the clearing edge has passed
    task automatic check_idle();
        @(posedge clk);
        @(negedge clk);
        check_value("done", done, 0);
        for (int e = 0; e < SIZE * SIZE; e++)
        begin
            check_value($sformatf("result[%0d][%0d]", e / SIZE, e % SIZE), result[e], 0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // One multiply run
    ////////////////////////////////////////////////////////////

    task automatic run_case(input int idx);
        run_cfg_t c;
        int       cycles;
        logic     got_done;
        c = cfg_table[idx];
        fill_operands(c);
        cfg           = c;
        start_mat_mul = 1'b1;
        cycles        = 0;
        got_done      = 1'b0;
        // At each falling edge, cycles equals the current clk_cnt
        while (!got_done && cycles < DONE_TIMEOUT)
        begin
            @(negedge clk);
            if (done)
            begin
                got_done = 1'b1;
            end
            else
            begin
                cycles++;
            end
        end
        assert (got_done)
        else
        begin
            $display("ERROR: case %0d, done never came within %0d cycles", idx, DONE_TIMEOUT);
            errors++;
        end
        if (got_done)
        begin
            check_value("done_cycle", cycles, done_cycle_table[idx]);
            compute_expected(c);
            for (int i = 0; i < SIZE; i++)
            begin
                for (int j = 0; j < SIZE; j++)
                begin
                    check_value($sformatf("result[%0d][%0d]", i, j),
                                result[i*SIZE+j], expected[i][j]);
                end
            end
        end
        wait_for_drive_slot();
        start_mat_mul = 1'b0;
        check_idle();
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        clk           = 1'b0;
        arst_n        = 1'b0;
        start_mat_mul = 1'b0;
        cfg           = '0;
        a_wr_en       = 1'b0;
        a_wr_addr     = '0;
        a_wr_data     = '0;
        b_wr_en       = 1'b0;
        b_wr_addr     = '0;
        b_wr_data     = '0;
        errors        = 0;
        void'($urandom(32'hce7b06ce));
        load_case_table();

        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_idle();

        for (int n = 0; n < NUM_CASES; n++)
        begin
            run_case(n);
        end

        $display("Ran %0d cases with %0d errors", NUM_CASES, errors);
        if (errors == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/matmul_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "matmul_params.svh"

module matmul_top
    import matmul_data_pkg::*;
    import matmul_cfg_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               start_mat_mul,
    input  run_cfg_t           cfg,
    input  logic               a_wr_en,
    input  logic [`AWIDTH-1:0] a_wr_addr,
    input  operand_row_u       a_wr_data,
    input  logic               b_wr_en,
    input  logic [`AWIDTH-1:0] b_wr_addr,
    input  operand_row_u       b_wr_data,
    output result_matrix_t     result,
    output logic               done
);

    run_status_t        status;
    logic [`AWIDTH-1:0] a_addr;
    logic [`AWIDTH-1:0] b_addr;
    operand_row_u       a_data;
    operand_row_u       b_data;
    skewed_operands_t   ops;

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////

    matmul_run_ctrl u_run_ctrl (
        .clk           (clk),
        .arst_n        (arst_n),
        .start_mat_mul (start_mat_mul),
        .cfg           (cfg),
        .status        (status),
        .done          (done)
    );

    ////////////////////////////////////////////////////////////
    // Operand memories
    ////////////////////////////////////////////////////////////

    // Holds A column by column
    operand_ram a_ram (
        .clk     (clk),
        .wr_en   (a_wr_en),
        .wr_addr (a_wr_addr),
        .wr_data (a_wr_data),
        .rd_addr (a_addr),
        .rd_data (a_data)
    );

    // Holds B row by row
    operand_ram b_ram (
        .clk     (clk),
        .wr_en   (b_wr_en),
        .wr_addr (b_wr_addr),
        .wr_data (b_wr_data),
        .rd_addr (b_addr),
        .rd_data (b_data)
    );

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////

    systolic_data_setup u_data_setup (
        .clk           (clk),
        .arst_n        (arst_n),
        .start_mat_mul (start_mat_mul),
        .cfg           (cfg),
        .status        (status),
        .a_addr        (a_addr),
        .b_addr        (b_addr),
        .a_data        (a_data),
        .b_data        (b_data),
        .ops           (ops)
    );

    systolic_mac_array u_mac_array (
        .clk           (clk),
        .arst_n        (arst_n),
        .start_mat_mul (start_mat_mul),
        .ops           (ops),
        .result        (result)
    );

endmodule

`default_nettype wire

//--- src/systolic_mac_array.sv
`timescale 1ns/100ps
`default_nettype none
`include "matmul_params.svh"

module systolic_mac_array
    import matmul_data_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    input  logic             start_mat_mul,
    input  skewed_operands_t ops,
    output result_matrix_t   result
);

    localparam int SIZE = `MAT_MUL_SIZE;

    // Registered copies that each cell hands to its right and lower neighbours
    elem_t a_fwd [SIZE][SIZE];
    elem_t b_fwd [SIZE][SIZE];
    acc_t  acc   [SIZE][SIZE];

    ////////////////////////////////////////////////////////////
    // Cell grid
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < SIZE; i++)
    begin : g_row
        for (genvar j = 0; j < SIZE; j++)
        begin : g_col
            elem_t                a_in;
            elem_t                b_in;
            logic [2*`DWIDTH-1:0] prod;

            // Column 0 takes row i of A straight from the setup stage
            if (j == 0)
            begin : g_a_edge
                assign a_in = ops.a_lane[i];
            end
            else
            begin : g_a_inner
                assign a_in = a_fwd[i][j-1];
            end

            // Row 0 takes column j of B straight from the setup stage
            if (i == 0)
            begin : g_b_edge
                assign b_in = ops.b_lane[j];
            end
            else
            begin : g_b_inner
                assign b_in = b_fwd[i-1][j];
            end

            assign prod = a_in * b_in;

            always_ff @(posedge clk or negedge arst_n)
            begin
                if (!arst_n)
                begin
                    a_fwd[i][j] <= '0;
                    b_fwd[i][j] <= '0;
                    acc[i][j]   <= '0;
                end
                else if (!start_mat_mul)
                begin
                    a_fwd[i][j] <= '0;
                    b_fwd[i][j] <= '0;
                    acc[i][j]   <= '0;
                end
                else
                begin
                    a_fwd[i][j] <= a_in;
                    b_fwd[i][j] <= b_in;
                    acc[i][j]   <= acc[i][j] + acc_t'(prod);
                end
            end
        end
    end

    // Row-major packing of the accumulators
    always_comb
    begin
        for (int i = 0; i < SIZE; i++)
        begin
            for (int j = 0; j < SIZE; j++)
            begin
                result[i*SIZE+j] = acc[i][j];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/systolic_data_setup.sv
`timescale 1ns/100ps
`default_nettype none
`include "matmul_params.svh"

module systolic_data_setup
    import matmul_data_pkg::*;
    import matmul_cfg_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               start_mat_mul,
    input  run_cfg_t           cfg,
    input  run_status_t        status,
    output logic [`AWIDTH-1:0] a_addr,
    output logic [`AWIDTH-1:0] b_addr,
    input  operand_row_u       a_data,
    input  operand_row_u       b_data,
    output skewed_operands_t   ops
);

    localparam int NUM_OPS = 2;
    localparam int OP_A    = 0;
    localparam int OP_B    = 1;
    localparam logic [`CNT_WIDTH-1:0] LATENCY = `MEM_ACCESS_LATENCY;

    slot_t              first_slot;
    slot_t              last_slot;
    slot_t              cnt;
    logic               in_window;
    logic [`AWIDTH-1:0] addr_q [NUM_OPS];
    lane_vec_t          skewed [NUM_OPS];

    // A and B share one start slot, so their reads stay aligned on k
    assign first_slot = run_first_slot(cfg);
    assign last_slot  = first_slot + slot_t'(cfg.final_mat_mul_size);
    assign cnt        = slot_t'(status.clk_cnt);
    assign in_window  = status.running && (cnt >= first_slot) && (cnt < last_slot);

    for (genvar p = 0; p < NUM_OPS; p++)
    begin : g_op
        logic [`AWIDTH-1:0]            base;
        logic [`ADDR_STRIDE_WIDTH-1:0] stride;
        logic [`MASK_WIDTH-1:0]        lane_mask;
        operand_row_u                  row;
        logic                          mem_access;
        logic [`CNT_WIDTH-1:0]         access_cnt;
        logic [`CNT_WIDTH-1:0]         elem_idx;
        logic                          data_valid;
        lane_vec_t                     qual;
        lane_vec_t [`MAT_MUL_SIZE-2:0] dly;

        // A lanes are matrix rows, B lanes are matrix columns
        assign base      = (p == OP_A) ? cfg.address_mat_a : cfg.address_mat_b;
        assign stride    = (p == OP_A) ? cfg.address_stride_a : cfg.address_stride_b;
        assign lane_mask = (p == OP_A) ? cfg.validity_mask_a_rows : cfg.validity_mask_b_cols;
        assign row       = (p == OP_A) ? a_data : b_data;

        ////////////////////////////////////////////////////////////
        // Address generation
        ////////////////////////////////////////////////////////////

        // Address k goes out on the edge that ends cycle S+k
        always_ff @(posedge clk or negedge arst_n)
        begin
            if (!arst_n)
            begin
                addr_q[p]  <= '0;
                mem_access <= 1'b0;
            end
            else if (!start_mat_mul)
            begin
                addr_q[p]  <= '0;
                mem_access <= 1'b0;
            end
            else if (in_window)
            begin
                addr_q[p]  <= (cnt == first_slot) ? base : addr_q[p] + stride;
                mem_access <= 1'b1;
            end
            else
            begin
                mem_access <= 1'b0;
            end
        end

        ////////////////////////////////////////////////////////////
        // Data qualification
        ////////////////////////////////////////////////////////////

        // Counts issued reads, so element k is on the data bus at count k+LATENCY
        always_ff @(posedge clk or negedge arst_n)
        begin
            if (!arst_n)
            begin
                access_cnt <= '0;
            end
            else if (!start_mat_mul || !mem_access)
            begin
                access_cnt <= '0;
            end
            else
            begin
                access_cnt <= access_cnt + 1'b1;
            end
        end

        assign elem_idx   = access_cnt - LATENCY;
        assign data_valid = (access_cnt >= LATENCY) && (elem_idx < `MASK_WIDTH)
            && cfg.validity_mask_a_cols_b_rows[elem_idx[`LOG2_MAT_MUL_SIZE-1:0]];

        always_comb
        begin
            for (int i = 0; i < `MAT_MUL_SIZE; i++)
            begin
                qual[i] = (data_valid && lane_mask[i]) ? row.lane[i] : '0;
            end
        end

        ////////////////////////////////////////////////////////////
        // Lane skew
        ////////////////////////////////////////////////////////////

        // dly[d] is the qualified word d+1 cycles ago
        always_ff @(posedge clk or negedge arst_n)
        begin
            if (!arst_n)
            begin
                dly <= '0;
            end
            else if (!start_mat_mul || (status.clk_cnt == '0))
            begin
                dly <= '0;
            end
            else
            begin
                dly[0] <= qual;
                for (int d = 1; d < `MAT_MUL_SIZE - 1; d++)
                begin
                    dly[d] <= dly[d-1];
                end
            end
        end

        // Lane i takes its element from the stage that is i cycles old
        always_comb
        begin
            skewed[p][0] = qual[0];
            for (int i = 1; i < `MAT_MUL_SIZE; i++)
            begin
                skewed[p][i] = dly[i-1][i];
            end
        end
    end

    assign a_addr = addr_q[OP_A];
    assign b_addr = addr_q[OP_B];
    assign ops    = '{a_lane: skewed[OP_A], b_lane: skewed[OP_B]};

endmodule

`default_nettype wire

//--- src/operand_ram.sv
`timescale 1ns/100ps
`default_nettype none
`include "matmul_params.svh"

module operand_ram
    import matmul_data_pkg::*;
(
    input  logic               clk,
    input  logic               wr_en,
    input  logic [`AWIDTH-1:0] wr_addr,
    input  operand_row_u       wr_data,
    input  logic [`AWIDTH-1:0] rd_addr,
    output operand_row_u       rd_data
);

    localparam int DEPTH = 2 ** `AWIDTH;

    logic [`MAT_MUL_SIZE*`DWIDTH-1:0] mem [DEPTH];

    // Write port, loaded from outside while no run is active
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data.flat;
        end
    end

    // Read port with one register stage, as a block RAM would have
    always_ff @(posedge clk)
    begin
        rd_data.flat <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- src/matmul_run_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "matmul_params.svh"

module matmul_run_ctrl
    import matmul_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        start_mat_mul,
    input  run_cfg_t    cfg,
    output run_status_t status,
    output logic        done
);

    logic [`CNT_WIDTH-1:0] clk_cnt;
    slot_t                 end_slot;

    ////////////////////////////////////////////////////////////
    // Run cycle counter
    ////////////////////////////////////////////////////////////

    // Zero in the first cycle of a run, then one step per cycle up to all ones
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            clk_cnt <= '0;
        end
        else if (!start_mat_mul)
        begin
            clk_cnt <= '0;
        end
        else if (clk_cnt != '1)
        begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Done level
    ////////////////////////////////////////////////////////////

    assign end_slot = run_done_slot(cfg);

    // Stays high because the counter never wraps
    assign done = start_mat_mul && (slot_t'(clk_cnt) >= end_slot);

    assign status.clk_cnt = clk_cnt;
    assign status.running = start_mat_mul && !done;

endmodule

`default_nettype wire

//--- src/matmul_cfg_pkg.sv
`default_nettype none
`include "matmul_params.svh"

package matmul_cfg_pkg;

    typedef struct packed
    {
        logic [`AWIDTH-1:0]            address_mat_a;
        logic [`AWIDTH-1:0]            address_mat_b;
        logic [`ADDR_STRIDE_WIDTH-1:0] address_stride_a;
        logic [`ADDR_STRIDE_WIDTH-1:0] address_stride_b;
        logic [`MASK_WIDTH-1:0]        validity_mask_a_rows;
        logic [`MASK_WIDTH-1:0]        validity_mask_a_cols_b_rows;
        logic [`MASK_WIDTH-1:0]        validity_mask_b_cols;
        logic [`CNT_WIDTH-1:0]         final_mat_mul_size;
        logic [`CNT_WIDTH-1:0]         start_slot;
    } run_cfg_t;

    typedef struct packed
    {
        logic [`CNT_WIDTH-1:0] clk_cnt;
        logic                  running;
    } run_status_t;

    // Wide enough for start_slot*4 plus the size plus the drain time
    typedef logic [`CNT_WIDTH+2:0] slot_t;

    // A slot is MAT_MUL_SIZE cycles long
    function automatic slot_t run_first_slot(input run_cfg_t cfg);
        return slot_t'(cfg.start_slot) << `LOG2_MAT_MUL_SIZE;
    endfunction

    // The last product leaves cell (3,3) well before this cycle
    function automatic slot_t run_done_slot(input run_cfg_t cfg);
        return run_first_slot(cfg) + slot_t'(cfg.final_mat_mul_size)
            + slot_t'(3 * `MAT_MUL_SIZE);
    endfunction

endpackage

`default_nettype wire

//--- src/matmul_data_pkg.sv
`default_nettype none
`include "matmul_params.svh"

package matmul_data_pkg;

    typedef logic [`DWIDTH-1:0] elem_t;
    typedef logic [`ACC_WIDTH-1:0] acc_t;

    // One element per lane, lane 0 in the low bits
    typedef elem_t [`MAT_MUL_SIZE-1:0] lane_vec_t;

    // The memory keeps a plain word while the setup stage slices it into lanes
    typedef union packed
    {
        logic [`MAT_MUL_SIZE*`DWIDTH-1:0] flat;
        lane_vec_t                        lane;
    } operand_row_u;

    // Lane i of each operand is already delayed by i cycles
    typedef struct packed
    {
        lane_vec_t a_lane;
        lane_vec_t b_lane;
    } skewed_operands_t;

    // Entry i*MAT_MUL_SIZE+j holds C[i][j]
    typedef acc_t [`MAT_MUL_SIZE*`MAT_MUL_SIZE-1:0] result_matrix_t;

endpackage

`default_nettype wire

//--- src/matmul_params.svh
`ifndef MATMUL_PARAMS_SVH
`define MATMUL_PARAMS_SVH

// Systolic array geometry
`define MAT_MUL_SIZE        4
`define LOG2_MAT_MUL_SIZE   2

// Element and accumulator widths
`define DWIDTH              8
`define ACC_WIDTH           18

// Operand memory addressing
`define AWIDTH              6
`define ADDR_STRIDE_WIDTH   6

// One mask bit per row, column or k index
`define MASK_WIDTH          4

// Read latency of the operand memories in cycles
`define MEM_ACCESS_LATENCY  1

// Width of the run cycle counter
`define CNT_WIDTH           8

`endif
